//--- verilog.f
+incdir+hw
hw/vec_pkg.sv
hw/vec_decode.sv
hw/vec_regfile.sv
hw/vec_alu.sv
hw/vec_mem_stage.sv
hw/vec_writeback.sv
hw/vec_core.sv
dv/vec_core_chk.sv
dv/vec_core_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := vec_core_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+1000
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/vec_core_tb.sv
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_core_tb;
    import vec_pkg::*;

    localparam int W         = `VEC_ELEM_WIDTH;
    localparam int LANES     = `VEC_LANES;
    localparam int NREGS     = `VEC_REG_COUNT;
    localparam int MEM_WORDS = 1 << `VEC_MEM_ADDR_WIDTH;
    // six tests averaging ~60 cycles plus reset, with wide margin
    localparam int TIMEOUT   = 2000;
    // write lands at A+4, so a reader is accepted at A+5 or later
    localparam int RAW_GAP   = 5;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_vld;
    instr_t    instr;
    vec_t      mem_rdata = '0;
    mem_addr_t mem_addr;
    logic      mem_ren;
    logic      mem_we;
    vec_t      mem_wdata;
    logic      data_out_vld;
    vec_t      data_out;
    reg_addr_t reg_wb;

    vec_t      mem [MEM_WORDS];
    vec_t      boot_mem [MEM_WORDS];
    vec_t      ref_mem [MEM_WORDS];
    vec_t      shadow [NREGS];
    int        last_wr [NREGS];
    vec_t      exp_data_q [$];
    reg_addr_t exp_vd_q [$];

    int slot;
    int tests;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    vec_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_vld    (instr_vld),
        .instr        (instr),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_ren      (mem_ren),
        .mem_we       (mem_we),
        .mem_wdata    (mem_wdata),
        .data_out_vld (data_out_vld),
        .data_out     (data_out),
        .reg_wb       (reg_wb)
    );

    always #20 clk = ~clk;

    // ========================================
    // memory model, read data valid next edge
    // ========================================

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= boot_mem[i];
            end
            mem_rdata <= '0;
        end else begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end
            if (mem_ren) begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

    // reports checked mid-cycle against the issue-order queue
    always @(negedge clk) begin
        if (rst_n && data_out_vld) begin
            if (exp_vd_q.size() == 0) begin
                $display("unexpected report for v%0d at %0t, no write pending", reg_wb, $time);
                errors++;
            end else begin
                checks++;
                assert (data_out == exp_data_q[0]) else begin
                    $display("Error %0t: data_out %h, expected %h", $time, data_out,
                             exp_data_q[0]);
                    errors++;
                end
                assert (reg_wb == exp_vd_q[0]) else begin
                    $display("Error %0t: reg_wb %0d, expected %0d", $time, reg_wb, exp_vd_q[0]);
                    errors++;
                end
                void'(exp_data_q.pop_front());
                void'(exp_vd_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

    // ========================================
    // reference model and drivers
    // ========================================

    // lane-wise, wraps at 16 bits, no carry between lanes
    function automatic vec_t expect_alu(input logic [2:0] opc, input vec_t a, input vec_t b);
        vec_t  r;
        elem_t x;
        elem_t y;
        r = '0;
        for (int i = 0; i < LANES; i++) begin
            x = a[i*W +: W];
            y = b[i*W +: W];
            case (opc)
                OP_ADD:  r[i*W +: W] = x + y;
                OP_SUB:  r[i*W +: W] = x - y;
                OP_AND:  r[i*W +: W] = x & y;
                default: r[i*W +: W] = x ^ y;
            endcase
        end
        return r;
    endfunction

    // unused middle bits carry noise
    function automatic instr_t encode(input logic [2:0] opc, input reg_addr_t vd,
                                      input reg_addr_t vs1, input reg_addr_t vs2,
                                      input mem_addr_t a);
        instr_t w;
        w        = instr_t'($urandom);
        w[31:29] = opc;
        w[28:26] = vd;
        w[25:23] = vs1;
        w[22:20] = vs2;
        w[7:0]   = a;
        return w;
    endfunction

    function automatic int fail_count();
        return errors + int'(dut0.u_chk.err_cnt);
    endfunction

    task automatic idle();
        @(posedge clk);
        instr_vld <= 1'b0;
        instr     <= instr_t'($urandom);
        slot++;
    endtask

    task automatic send(input instr_t w);
        logic [2:0] opc;
        logic       is_alu;
        logic       rd_b;
        vec_t       res;
        opc    = w[31:29];
        is_alu = opc inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
        rd_b   = is_alu || (opc == OP_STORE);
        // hold a reader back until its sources are written
        while ((is_alu && slot + 1 - last_wr[w[25:23]] < RAW_GAP) ||
               (rd_b && slot + 1 - last_wr[w[22:20]] < RAW_GAP)) begin
            idle();
        end
        @(posedge clk);
        instr_vld <= 1'b1;
        instr     <= w;
        slot++;
        res = is_alu ? expect_alu(opc, shadow[w[25:23]], shadow[w[22:20]]) : ref_mem[w[7:0]];
        if (opc == OP_STORE) begin
            ref_mem[w[7:0]] = shadow[w[22:20]];
        end
        if (is_alu || opc == OP_LOAD) begin
            shadow[w[28:26]]  = res;
            last_wr[w[28:26]] = slot;
            exp_data_q.push_back(res);
            exp_vd_q.push_back(w[28:26]);
        end
    endtask

    // wait out pending reports, then a few cycles for stray ones
    task automatic drain();
        while (exp_vd_q.size() != 0) begin
            idle();
        end
        repeat (4) idle();
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s: done, %0d errors", tests, name, fail_count() - err_start);
    endtask

    // ========================================
    // tests
    // ========================================

    initial begin
        int        err_start;
        mem_addr_t a;
        void'($urandom(1988));
        rst_n     <= 1'b0;
        instr_vld <= 1'b0;
        instr     <= '0;
        slot  = 0;
        tests = 0;
        for (int i = 0; i < NREGS; i++) begin
            shadow[i]  = '0;
            last_wr[i] = -RAW_GAP;
        end
        // words 0-15 stay zero, 16 and 17 hold lane-wrap operands
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < 16) begin
                boot_mem[i] = '0;
            end else begin
                boot_mem[i] = {$urandom, $urandom};
            end
        end
        boot_mem[16] = 64'hffff_ffff_ffff_ffff;
        boot_mem[17] = 64'h0001_0001_0001_0001;
        ref_mem = boot_mem;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        err_start = fail_count();
        send(encode(OP_XOR, 3'd0, 3'd1, 3'd2, 8'd0));
        for (int i = 0; i < NREGS; i++) begin
            send(encode(OP_LOAD, reg_addr_t'(i), 3'd0, 3'd0, mem_addr_t'(i)));
        end
        drain();
        end_test("reset state and zero loads", err_start);

        err_start = fail_count();
        for (int i = 0; i < NREGS; i++) begin
            send(encode(OP_LOAD, reg_addr_t'(i), 3'd0, 3'd0, mem_addr_t'($urandom_range(18, 255))));
        end
        drain();
        end_test("random loads", err_start);

        err_start = fail_count();
        send(encode(OP_LOAD, 3'd5, 3'd0, 3'd0, 8'd16));
        send(encode(OP_LOAD, 3'd6, 3'd0, 3'd0, 8'd17));
        send(encode(OP_ADD, 3'd7, 3'd5, 3'd6, 8'd0));
        send(encode(OP_SUB, 3'd4, 3'd6, 3'd5, 8'd0));
        for (int i = 0; i < 16; i++) begin
            send(encode(3'(1 + i % 4), reg_addr_t'($urandom), reg_addr_t'($urandom),
                        reg_addr_t'($urandom), 8'd0));
        end
        drain();
        end_test("alu lane ops", err_start);

        err_start = fail_count();
        for (int i = 0; i < 4; i++) begin
            a = mem_addr_t'($urandom_range(18, 255));
            send(encode(OP_STORE, 3'd0, 3'd0, reg_addr_t'($urandom), a));
            drain();
            send(encode(OP_LOAD, reg_addr_t'($urandom), 3'd0, 3'd0, a));
            drain();
        end
        end_test("store then load", err_start);

        // loads fill v0-v3 while the alu ops read only v4 and v5
        err_start = fail_count();
        for (int i = 0; i < 4; i++) begin
            send(encode(OP_LOAD, reg_addr_t'(i), 3'd0, 3'd0, mem_addr_t'($urandom_range(18, 255))));
        end
        for (int i = 0; i < 4; i++) begin
            send(encode(3'(1 + i), reg_addr_t'(6 + i % 2), 3'd4, 3'd5, 8'd0));
        end
        drain();
        end_test("back to back issue", err_start);

        err_start = fail_count();
        for (int i = 0; i < 40; i++) begin
            send(encode(3'($urandom), reg_addr_t'($urandom), reg_addr_t'($urandom),
                        reg_addr_t'($urandom), mem_addr_t'($urandom)));
        end
        drain();
        end_test("random mix", err_start);

        $display("tests %0d, reports checked %0d, errors %0d", tests, checks, fail_count());
        if (fail_count() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/vec_core_chk.sv
`timescale 1ns/1ps

module vec_core_chk (
    input logic          clk,
    input logic          rst_n,
    input logic          alu_issue,
    input logic          load_issue,
    input logic          store_issue,
    input logic          mem_ren,
    input logic          mem_we,
    input logic          data_out_vld
);

    // running count of assertion failures
    int unsigned err_cnt = 0;

    // ========================================
    // memory request
    // ========================================

    a_req_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ren && mem_we))
        else begin
            $error("mem_ren and mem_we high in the same cycle");
            err_cnt++;
        end

    // strobe in the cycle right after the accept edge, for one cycle
    a_ren_issue: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ren == $past(load_issue))
        else begin
            $error("mem_ren does not follow the load issue by one cycle");
            err_cnt++;
        end

    a_we_issue: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we == $past(store_issue))
        else begin
            $error("mem_we does not follow the store issue by one cycle");
            err_cnt++;
        end

    // quiet while reset is sampled low and on the next sample
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!mem_ren && !mem_we && !data_out_vld))
        else begin
            $error("request or report active during reset");
            err_cnt++;
        end

    // ========================================
    // write-back report
    // ========================================

    // issue is sampled before the accept edge, so 3 cycles show up as 4 samples
    a_report_lat: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_vld == $past(alu_issue || load_issue, 4))
        else begin
            $error("data_out_vld not exactly three cycles after a load or alu accept");
            err_cnt++;
        end

endmodule

bind vec_core vec_core_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_issue    (alu_issue),
    .load_issue   (load_issue),
    .store_issue  (store_issue),
    .mem_ren      (mem_ren),
    .mem_we       (mem_we),
    .data_out_vld (data_out_vld)
);

//--- hw/vec_core.sv
`timescale 1ns/1ps

module vec_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_vld,
    input  vec_pkg::instr_t     instr,
    input  vec_pkg::vec_t       mem_rdata,
    output vec_pkg::mem_addr_t  mem_addr,
    output logic                mem_ren,
    output logic                mem_we,
    output vec_pkg::vec_t       mem_wdata,
    output logic                data_out_vld,
    output vec_pkg::vec_t       data_out,
    output vec_pkg::reg_addr_t  reg_wb
);
    import vec_pkg::*;

    // decode outputs
    reg_addr_t vs1_addr;
    reg_addr_t vs2_addr;
    reg_addr_t vd_addr;
    mem_addr_t addr;
    opcode_t   op;
    logic      alu_issue;
    logic      load_issue;
    logic      store_issue;
    logic      reg_we;
    wb_sel_t   wb_sel;

    // register file ports
    vec_t      rd_data_a;
    vec_t      rd_data_b;
    logic      rf_we;
    reg_addr_t rf_addr;
    vec_t      rf_data;

    // execute results
    vec_t      alu_result;
    vec_t      load_data;

    // ========================================
    // decode and operand read
    // ========================================

    vec_decode u_decode (
        .instr_vld   (instr_vld),
        .instr       (instr),
        .vs1_addr    (vs1_addr),
        .vs2_addr    (vs2_addr),
        .vd_addr     (vd_addr),
        .addr        (addr),
        .op          (op),
        .alu_issue   (alu_issue),
        .load_issue  (load_issue),
        .store_issue (store_issue),
        .reg_we      (reg_we),
        .wb_sel      (wb_sel)
    );

    vec_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (vs1_addr),
        .rd_addr_b (vs2_addr),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .we        (rf_we),
        .wr_addr   (rf_addr),
        .wr_data   (rf_data)
    );

    // ========================================
    // execute, both units on the same instr
    // ========================================

    vec_alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (alu_issue),
        .op     (op),
        .src_a  (rd_data_a),
        .src_b  (rd_data_b),
        .result (alu_result)
    );

    // store data is the vs2 vector
    vec_mem_stage u_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_issue  (load_issue),
        .store_issue (store_issue),
        .addr        (addr),
        .store_data  (rd_data_b),
        .mem_addr    (mem_addr),
        .mem_ren     (mem_ren),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .load_data   (load_data)
    );

    vec_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_we       (reg_we),
        .vd_addr      (vd_addr),
        .wb_sel       (wb_sel),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .rf_we        (rf_we),
        .rf_addr      (rf_addr),
        .rf_data      (rf_data),
        .data_out_vld (data_out_vld),
        .data_out     (data_out),
        .reg_wb       (reg_wb)
    );

endmodule

//--- hw/vec_writeback.sv
`timescale 1ns/1ps

module vec_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                reg_we,
    input  vec_pkg::reg_addr_t  vd_addr,
    input  vec_pkg::wb_sel_t    wb_sel,
    input  vec_pkg::vec_t       alu_result,
    input  vec_pkg::vec_t       load_data,
    output logic                rf_we,
    output vec_pkg::reg_addr_t  rf_addr,
    output vec_pkg::vec_t       rf_data,
    output logic                data_out_vld,
    output vec_pkg::vec_t       data_out,
    output vec_pkg::reg_addr_t  reg_wb
);
    import vec_pkg::*;

    // capture at acceptance, then two more to line up with the results
    localparam int TAG_STAGES = 3;

    logic      we_q  [TAG_STAGES];
    reg_addr_t vd_q  [TAG_STAGES];
    wb_sel_t   sel_q [TAG_STAGES];
    vec_t      sel_data;

    // ========================================
    // destination tag pipeline
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TAG_STAGES; i++) begin
                we_q[i]  <= 1'b0;
                vd_q[i]  <= '0;
                sel_q[i] <= WB_NONE;
            end
            rf_we   <= 1'b0;
            rf_addr <= '0;
        end else begin
            we_q[0]  <= reg_we;
            vd_q[0]  <= vd_addr;
            sel_q[0] <= wb_sel;
            for (int i = 1; i < TAG_STAGES; i++) begin
                we_q[i]  <= we_q[i-1];
                vd_q[i]  <= vd_q[i-1];
                sel_q[i] <= sel_q[i-1];
            end
            rf_we   <= we_q[TAG_STAGES-1];
            rf_addr <= vd_q[TAG_STAGES-1];
        end
    end

    // both units hold their result here
    always_comb begin
        case (sel_q[TAG_STAGES-1])
            WB_ALU:  sel_data = alu_result;
            WB_MEM:  sel_data = load_data;
            default: sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rf_data <= sel_data;
    end

    // report mirrors the regfile write
    assign data_out_vld = rf_we;
    assign data_out     = rf_data;
    assign reg_wb       = rf_addr;

endmodule

//--- hw/vec_mem_stage.sv
`timescale 1ns/1ps

module vec_mem_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_issue,
    input  logic                store_issue,
    input  vec_pkg::mem_addr_t  addr,
    input  vec_pkg::vec_t       store_data,
    output vec_pkg::mem_addr_t  mem_addr,
    output logic                mem_ren,
    output logic                mem_we,
    output vec_pkg::vec_t       mem_wdata,
    input  vec_pkg::vec_t       mem_rdata,
    output vec_pkg::vec_t       load_data
);

    // read in flight, data due at the next edge
    logic ren_q;

    // request strobes last one cycle per issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ren <= 1'b0;
            mem_we  <= 1'b0;
            ren_q   <= 1'b0;
        end else begin
            mem_ren <= load_issue;
            mem_we  <= store_issue;
            ren_q   <= mem_ren;
        end
    end

    always_ff @(posedge clk) begin
        if (load_issue || store_issue) begin
            mem_addr <= addr;
        end
        if (store_issue) begin
            mem_wdata <= store_data;
        end
        if (ren_q) begin
            load_data <= mem_rdata;
        end
    end

endmodule

//--- hw/vec_alu.sv
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  vec_pkg::opcode_t  op,
    input  vec_pkg::vec_t     src_a,
    input  vec_pkg::vec_t     src_b,
    output vec_pkg::vec_t     result
);
    import vec_pkg::*;

    localparam int W = `VEC_ELEM_WIDTH;

    logic    vld_q1;
    logic    vld_q2;
    opcode_t op_q;
    vec_t    a_q;
    vec_t    b_q;
    vec_t    arith_d;
    vec_t    logic_d;
    vec_t    arith_q;
    vec_t    logic_q;
    logic    sel_logic_q;

    // ========================================
    // stage valids and opcode
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q1 <= 1'b0;
            vld_q2 <= 1'b0;
            op_q   <= OP_NOP;
        end else begin
            vld_q1 <= issue;
            vld_q2 <= vld_q1;
            if (issue) begin
                op_q <= op;
            end
        end
    end

    // per-lane math, wraps inside each element
    for (genvar i = 0; i < `VEC_LANES; i++) begin : g_lane
        elem_t ea;
        elem_t eb;
        assign ea = a_q[i*W +: W];
        assign eb = b_q[i*W +: W];
        assign arith_d[i*W +: W] = (op_q == OP_SUB) ? ea - eb : ea + eb;
        assign logic_d[i*W +: W] = (op_q == OP_XOR) ? ea ^ eb : ea & eb;
    end

    // operands at acceptance, lane results next, final select last
    always_ff @(posedge clk) begin
        if (issue) begin
            a_q <= src_a;
            b_q <= src_b;
        end
        if (vld_q1) begin
            arith_q     <= arith_d;
            logic_q     <= logic_d;
            sel_logic_q <= (op_q == OP_AND) || (op_q == OP_XOR);
        end
        if (vld_q2) begin
            result <= sel_logic_q ? logic_q : arith_q;
        end
    end

endmodule

//--- hw/vec_regfile.sv
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  vec_pkg::reg_addr_t  rd_addr_a,
    input  vec_pkg::reg_addr_t  rd_addr_b,
    output vec_pkg::vec_t       rd_data_a,
    output vec_pkg::vec_t       rd_data_b,
    input  logic                we,
    input  vec_pkg::reg_addr_t  wr_addr,
    input  vec_pkg::vec_t       wr_data
);
    import vec_pkg::*;

    vec_t regs [`VEC_REG_COUNT];

    // single write port, cleared at reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VEC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // async reads, no bypass of a same-cycle write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- hw/vec_decode.sv
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_decode (
    input  logic                instr_vld,
    input  vec_pkg::instr_t     instr,
    output vec_pkg::reg_addr_t  vs1_addr,
    output vec_pkg::reg_addr_t  vs2_addr,
    output vec_pkg::reg_addr_t  vd_addr,
    output vec_pkg::mem_addr_t  addr,
    output vec_pkg::opcode_t    op,
    output logic                alu_issue,
    output logic                load_issue,
    output logic                store_issue,
    output logic                reg_we,
    output vec_pkg::wb_sel_t    wb_sel
);
    import vec_pkg::*;

    // field layout, packed down from the msb
    localparam int OP_W    = $bits(opcode_t);
    localparam int RA_W    = $bits(reg_addr_t);
    localparam int OP_LSB  = `VEC_INSTR_WIDTH - OP_W;
    localparam int VD_LSB  = OP_LSB - RA_W;
    localparam int VS1_LSB = VD_LSB - RA_W;
    localparam int VS2_LSB = VS1_LSB - RA_W;

    logic [OP_W-1:0] op_field;

    assign op_field = instr[OP_LSB +: OP_W];
    assign vd_addr  = instr[VD_LSB +: RA_W];
    assign vs1_addr = instr[VS1_LSB +: RA_W];
    assign vs2_addr = instr[VS2_LSB +: RA_W];
    assign addr     = instr[$bits(mem_addr_t)-1:0];

    // issue controls, all quiet without a strobe
    always_comb begin
        op          = OP_NOP;
        alu_issue   = 1'b0;
        load_issue  = 1'b0;
        store_issue = 1'b0;
        reg_we      = 1'b0;
        wb_sel      = WB_NONE;
        if (instr_vld) begin
            case (op_field)
                OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                    op        = opcode_t'(op_field);
                    alu_issue = 1'b1;
                    reg_we    = 1'b1;
                    wb_sel    = WB_ALU;
                end
                OP_LOAD: begin
                    op         = OP_LOAD;
                    load_issue = 1'b1;
                    reg_we     = 1'b1;
                    wb_sel     = WB_MEM;
                end
                OP_STORE: begin
                    op          = OP_STORE;
                    store_issue = 1'b1;
                end
                // nop and the unused code 7
                default: op = OP_NOP;
            endcase
        end
    end

endmodule

//--- hw/vec_pkg.sv
`include "vec_params.svh"

package vec_pkg;

    // element and flat vector, lane 0 in the low bits
    typedef logic [`VEC_ELEM_WIDTH-1:0]            elem_t;
    typedef logic [`VEC_LANES*`VEC_ELEM_WIDTH-1:0] vec_t;

    typedef logic [$clog2(`VEC_REG_COUNT)-1:0]     reg_addr_t;
    typedef logic [`VEC_MEM_ADDR_WIDTH-1:0]        mem_addr_t;
    typedef logic [`VEC_INSTR_WIDTH-1:0]           instr_t;

    // top 3 bits of the instruction, code 7 is treated as nop
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_AND   = 3'd3,
        OP_XOR   = 3'd4,
        OP_LOAD  = 3'd5,
        OP_STORE = 3'd6
    } opcode_t;

    // result source for write-back
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_sel_t;

endpackage

//--- hw/vec_params.svh
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// ========================================
// vector core sizing
// ========================================

// lanes per vector
`define VEC_LANES          4
// bits per lane element
`define VEC_ELEM_WIDTH     16
// architectural vector registers
`define VEC_REG_COUNT      8
// data memory word address
`define VEC_MEM_ADDR_WIDTH 8
// instruction word
`define VEC_INSTR_WIDTH    32

`endif
